/* src/strm_cfg_pkg.sv */
/*
  Job control for the load streamer.
  base_addr must be aligned to a beat and len_bytes must be at least 1.
  tot_len must equal len_bytes / STRB_W rounded up, and d0_stride must equal STRB_W.
  The free-slot counters are SLOT_W bits wide, so FIFO_DEPTH must stay below 2**SLOT_W.
*/
`default_nettype none

package strm_cfg_pkg;

    parameter int unsigned DATA_W = 64;          // default beat width in bits.
    parameter int unsigned STRB_W = DATA_W / 8;  // bytes per beat.
    parameter int unsigned SLOT_W = 8;           // width of buffer free / in-flight counts.

    typedef struct packed {
        logic [31:0] base_addr;  // byte address of the first beat.
        logic [19:0] len_bytes;  // vector length in bytes.
        logic [15:0] tot_len;    // number of beats in the job.
        logic [15:0] d0_stride;  // byte step between beats.
    } strm_cfg_t;

endpackage

`default_nettype wire

/* src/strm_beat_pkg.sv */
/*
  Stream beat and memory port types.
  All payload widths follow DATA_W from the configuration package.
  A request is taken in a cycle where req and gnt are both high.
  r_valid comes exactly one cycle after the grant and carries that word.
*/
`default_nettype none

package strm_beat_pkg;

    import strm_cfg_pkg::*;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;  // one bit per valid byte.
    } strm_beat_t;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;  // byte address, beat aligned.
    } mem_req_t;

    typedef struct packed {
        logic              gnt;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* src/strm_addr_gen.sv */
/*
  Address generator for the load streamer.
  Issues one word request per beat, stepping by d0_stride from base_addr.
  A request is only raised while the response buffer has room for every
  outstanding word, so a returning word always finds a free slot.
  clear_i drops the request in the same cycle and abandons the job.
*/
`timescale 1ns/1ns
`default_nettype none

module strm_addr_gen
    import strm_cfg_pkg::*;
    import strm_beat_pkg::*;
#(
    parameter int unsigned DW = DATA_W
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              clear_i,
    input  logic              start_i,
    input  strm_cfg_t         cfg_i,
    input  logic [SLOT_W-1:0] free_slots_i,
    input  mem_rsp_t          mem_rsp_i,
    output mem_req_t          mem_req_o,
    output logic              busy_o
);

    localparam int unsigned OFFS_W = $clog2(DW / 8);

    logic [31:0]       addr_q;
    logic [15:0]       beats_left_q;
    logic [SLOT_W-1:0] inflight_q;  // granted words whose data has not returned yet.
    logic              req;
    logic              grant;

    assign req   = (beats_left_q != '0) && (free_slots_i > inflight_q) && !clear_i;
    assign grant = req & mem_rsp_i.gnt;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q       <= '0;
            beats_left_q <= '0;
        end else if (clear_i) begin
            addr_q       <= '0;
            beats_left_q <= '0;
        end else if (start_i) begin
            addr_q       <= cfg_i.base_addr;
            beats_left_q <= cfg_i.tot_len;
        end else if (grant) begin
            addr_q       <= addr_q + 32'(cfg_i.d0_stride);  // next beat.
            beats_left_q <= beats_left_q - 16'd1;
        end
    end

    // rises on grant, falls when the word comes back.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            inflight_q <= '0;
        end else if (clear_i) begin
            inflight_q <= '0;
        end else if (grant && !mem_rsp_i.r_valid) begin
            inflight_q <= inflight_q + 1'b1;
        end else if (!grant && mem_rsp_i.r_valid && (inflight_q != '0)) begin
            inflight_q <= inflight_q - 1'b1;
        end
    end

    assign mem_req_o.req  = req;
    assign mem_req_o.addr = {addr_q[31:OFFS_W], {OFFS_W{1'b0}}};  // keep beat alignment.

    assign busy_o = (beats_left_q != '0) || (inflight_q != '0);

endmodule

`default_nettype wire

/* src/strm_resp_fifo.sv */
/*
  Response buffer for returning read words.
  A word pushed in one cycle is at the head in the next one.
  The address generator throttles requests, so a push never meets a full buffer;
  a push into a full buffer would be dropped.
  clear_i empties the buffer and wins over a push in the same cycle.
*/
`timescale 1ns/1ns
`default_nettype none

module strm_resp_fifo
    import strm_cfg_pkg::*;
#(
    parameter int unsigned DW         = DATA_W,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              clear_i,
    input  logic              push_i,
    input  logic [DW-1:0]     push_data_i,
    output logic              pop_valid_o,
    output logic [DW-1:0]     pop_data_o,
    input  logic              pop_ready_i,
    output logic [SLOT_W-1:0] free_slots_o
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [DW-1:0]     mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [SLOT_W-1:0] cnt_q;
    logic              push_ok;
    logic              pop_ok;

    assign push_ok = push_i && (cnt_q != SLOT_W'(FIFO_DEPTH));
    assign pop_ok  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign pop_valid_o  = (cnt_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];  // head read straight from storage.
    assign free_slots_o = SLOT_W'(FIFO_DEPTH) - cnt_q;

endmodule

`default_nettype wire

/* src/strm_strb_gen.sv */
/*
  Strobe generator for the load stream.
  Valid, ready and data pass straight through; only the strobe is computed.
  On the final beat of a job the bytes past len_bytes are masked off.
  The beat counter wraps after tot_len handshakes, so back-to-back jobs need no restart.
*/
`timescale 1ns/1ns
`default_nettype none

module strm_strb_gen
    import strm_cfg_pkg::*;
    import strm_beat_pkg::*;
#(
    parameter int unsigned DW = DATA_W
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          clear_i,
    input  strm_cfg_t     cfg_i,
    input  logic          in_valid_i,
    input  logic [DW-1:0] in_data_i,
    output logic          in_ready_o,
    output logic          out_valid_o,
    output strm_beat_t    out_o,
    input  logic          out_ready_i,
    output logic          last_o
);

    localparam int unsigned BYTES  = DW / 8;
    localparam int unsigned OFFS_W = $clog2(BYTES);

    logic [15:0]       beat_cnt_q;
    logic [15:0]       last_idx;
    logic [OFFS_W-1:0] stride_msk;
    logic [OFFS_W-1:0] lftovr;      // valid bytes in the final beat, zero means full.
    logic [BYTES-1:0]  final_strb;

    assign stride_msk = cfg_i.d0_stride[OFFS_W-1:0] + {OFFS_W{1'b1}};
    assign lftovr     = cfg_i.len_bytes[OFFS_W-1:0] & stride_msk;
    assign last_idx   = cfg_i.tot_len - 16'd1;
    assign last_o     = (beat_cnt_q == last_idx);

    always_comb begin
        final_strb = '1;
        for (int i = 0; i < BYTES; i++) begin
            if ((lftovr != '0) && (i >= int'(lftovr))) begin
                final_strb[i] = 1'b0;  // byte lies past the end of the vector.
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_cnt_q <= '0;
        end else if (clear_i) begin
            beat_cnt_q <= '0;
        end else if (in_valid_i && out_ready_i) begin
            beat_cnt_q <= last_o ? 16'd0 : beat_cnt_q + 16'd1;
        end
    end

    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;
    assign out_o.data  = in_data_i;
    assign out_o.strb  = last_o ? final_strb : '1;

endmodule

`default_nettype wire

/* src/strm_load_top.sv */
/*
  Load streamer top level.
  cfg_i must stay stable from start_i until done_o.
  DW must equal DATA_W of the configuration package, since the beat and
  memory types follow the package width.
  busy_o covers the fetch side; done_o pulses one cycle after the last beat is taken.
*/
`timescale 1ns/1ns
`default_nettype none

module strm_load_top
    import strm_cfg_pkg::*;
    import strm_beat_pkg::*;
#(
    parameter int unsigned DW         = DATA_W,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       clear_i,
    input  logic       start_i,
    input  strm_cfg_t  cfg_i,
    output mem_req_t   mem_req_o,
    input  mem_rsp_t   mem_rsp_i,
    output strm_beat_t beat_o,
    output logic       beat_valid_o,
    input  logic       beat_ready_i,
    output logic       busy_o,
    output logic       done_o
);

    logic [SLOT_W-1:0] free_slots;
    logic              fifo_valid;
    logic [DW-1:0]     fifo_data;
    logic              fifo_ready;
    logic              last;
    logic              done_q;

    strm_addr_gen #(
        .DW (DW)
    ) i_addr_gen (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (clear_i),
        .start_i      (start_i),
        .cfg_i        (cfg_i),
        .free_slots_i (free_slots),
        .mem_rsp_i    (mem_rsp_i),
        .mem_req_o    (mem_req_o),
        .busy_o       (busy_o)
    );

    strm_resp_fifo #(
        .DW         (DW),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_resp_fifo (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (clear_i),
        .push_i       (mem_rsp_i.r_valid),
        .push_data_i  (mem_rsp_i.r_data),
        .pop_valid_o  (fifo_valid),
        .pop_data_o   (fifo_data),
        .pop_ready_i  (fifo_ready),
        .free_slots_o (free_slots)
    );

    strm_strb_gen #(
        .DW (DW)
    ) i_strb_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .cfg_i       (cfg_i),
        .in_valid_i  (fifo_valid),
        .in_data_i   (fifo_data),
        .in_ready_o  (fifo_ready),
        .out_valid_o (beat_valid_o),
        .out_o       (beat_o),
        .out_ready_i (beat_ready_i),
        .last_o      (last)
    );

    // final beat handshake marks the end of the job.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_q <= 1'b0;
        end else if (clear_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= beat_valid_o & beat_ready_i & last;
        end
    end

    assign done_o = done_q;

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
/*
  Clock and reset source for the testbench.
  Reset is released on a falling edge, away from the active clock edge.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS  = 4,
    parameter int unsigned RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;  // active edge stays clean.
    end

endmodule

`default_nettype wire

/* verif/tb_mem_model.sv */
/*
  Byte-addressed read memory for the testbench.
  Only the low ADDR_W address bits select a byte, so the space wraps.
  gnt follows gnt_en_i; read data returns exactly one cycle after a grant.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model
    import strm_cfg_pkg::*;
    import strm_beat_pkg::*;
#(
    parameter int unsigned ADDR_W = 12
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     gnt_en_i,
    input  mem_req_t mem_req_i,
    output mem_rsp_t mem_rsp_o
);

    localparam int unsigned MEM_BYTES = 1 << ADDR_W;

    logic [7:0]        mem [MEM_BYTES];
    logic              r_valid_q;
    logic [DATA_W-1:0] r_data_q;

    // every address bit folds into the byte value.
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [DATA_W-1:0] read_word(input logic [31:0] addr);
        logic [DATA_W-1:0] w;
        for (int b = 0; b < STRB_W; b++) begin
            w[8*b +: 8] = mem[ADDR_W'(addr + 32'(b))];  // little endian.
        end
        return w;
    endfunction

    initial begin
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = fill_byte(32'(a));
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            r_valid_q <= 1'b0;
            r_data_q  <= '0;
        end else begin
            r_valid_q <= mem_req_i.req && gnt_en_i;
            if (mem_req_i.req && gnt_en_i) begin
                r_data_q <= read_word(mem_req_i.addr);
            end
        end
    end

    assign mem_rsp_o.gnt     = gnt_en_i;
    assign mem_rsp_o.r_valid = r_valid_q;
    assign mem_rsp_o.r_data  = r_data_q;

endmodule

`default_nettype wire

/* verif/tb_strm_load_top.sv */
/*
  Directed testbench for the load streamer.
  Inputs change on the falling edge; outputs are sampled there too.
  Expected data follows the memory fill rule, 8 bytes per beat, stride 8.
  Grants and ready are random from a fixed-seed xorshift; the run stops at the first error.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_strm_load_top
    import strm_cfg_pkg::*;
    import strm_beat_pkg::*;
();

    localparam int BEAT_TIMEOUT = 400;  // cycles per beat or per wait.

    logic       clk;
    logic       rst_n;
    strm_cfg_t  cfg;
    logic       start;
    logic       clear;
    logic       gnt_en;
    logic       beat_ready;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    strm_beat_t beat;
    logic       beat_valid;
    logic       busy;
    logic       done;

    logic [31:0] rnd_state = 32'h6e14_a5d3;
    int          ready_pct = 100;
    logic        valid_s;   // outputs as seen at the last falling edge.
    strm_beat_t  beat_s;
    logic        done_s;
    logic        busy_s;
    logic        req_s;

    tb_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(5)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

    tb_mem_model i_mem_model (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .gnt_en_i  (gnt_en),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    strm_load_top #(.DW(DATA_W), .FIFO_DEPTH(4)) i_strm_load_top (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .clear_i      (clear),
        .start_i      (start),
        .cfg_i        (cfg),
        .mem_req_o    (mem_req),
        .mem_rsp_i    (mem_rsp),
        .beat_o       (beat),
        .beat_valid_o (beat_valid),
        .beat_ready_i (beat_ready),
        .busy_o       (busy),
        .done_o       (done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [63:0] expected_word(input logic [31:0] addr);
        logic [63:0] w;
        logic [31:0] a;
        for (int b = 0; b < 8; b++) begin
            a = addr + 32'(b);
            w[8*b +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
        end
        return w;
    endfunction

    // only the final beat of a ragged vector is partial.
    function automatic logic [7:0] expected_strb(input int len, input int idx, input int tot);
        int rem;
        rem = len % 8;
        if ((idx == tot - 1) && (rem != 0)) begin
            return 8'((1 << rem) - 1);
        end
        return 8'hff;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout at %0t ns: %s", $time, why);
        $display("Simulation failed");
        $fatal(1, "stopping on a timeout");
    endtask

    // sample outputs first, then drive the next set of inputs.
    task automatic next_cycle();
        @(negedge clk);
        valid_s   = beat_valid;
        beat_s    = beat;
        done_s    = done;
        busy_s    = busy;
        req_s     = mem_req.req;
        start     = 1'b0;
        clear     = 1'b0;
        rnd_state = xorshift32(rnd_state);
        gnt_en    = (rnd_state[2:0] < 3'd5);
        rnd_state = xorshift32(rnd_state);
        beat_ready = (int'(rnd_state % 32'd100) < ready_pct);
    endtask

    task automatic start_job(input logic [31:0] base, input int len);
        next_cycle();
        cfg.base_addr = base;
        cfg.len_bytes = 20'(len);
        cfg.tot_len   = 16'((len + 7) / 8);
        cfg.d0_stride = 16'd8;
        start         = 1'b1;
    endtask

    task automatic collect_beats(input logic [31:0] base, input int len, input int count);
        int         tot;
        int         idx;
        int         waited;
        logic       hold;
        strm_beat_t held;
        tot    = (len + 7) / 8;
        idx    = 0;
        waited = 0;
        hold   = 1'b0;
        while (idx < count) begin
            next_cycle();
            if (hold) begin  // stalled beat must not move.
                check_equal(64'(valid_s), 64'd1, "valid dropped while stalled");
                check_equal(beat_s.data, held.data, "data changed while stalled");
                check_equal(64'(beat_s.strb), 64'(held.strb), "strb changed while stalled");
            end
            if (valid_s && beat_ready) begin
                check_equal(beat_s.data, expected_word(base + 32'(idx * 8)), "beat data");
                check_equal(64'(beat_s.strb), 64'(expected_strb(len, idx, tot)), "beat strb");
                idx++;
                waited = 0;
                hold   = 1'b0;
            end else begin
                hold   = valid_s;
                held   = beat_s;
                waited++;
                if (waited > BEAT_TIMEOUT) abort_run("no output beat arrived");
            end
        end
    endtask

    task automatic expect_done();
        int waited;
        waited = 0;
        do begin
            next_cycle();
            waited++;
            if (waited > BEAT_TIMEOUT) abort_run("done never pulsed");
        end while (!done_s);
        check_equal(64'(waited), 64'd1, "cycles from last beat to done");
        check_equal(64'(busy_s), 64'd0, "busy at done");
    endtask

    task automatic run_job(input logic [31:0] base, input int len);
        start_job(base, len);
        collect_beats(base, len, (len + 7) / 8);
        expect_done();
    endtask

    task automatic aligned_length();
        ready_pct = 80;
        run_job(32'h0000_0100, 64);
    endtask

    task automatic odd_length();
        ready_pct = 80;
        run_job(32'h0000_0240, 61);  // last beat keeps 5 bytes.
    endtask

    task automatic single_beat();
        ready_pct = 80;
        run_job(32'h0000_03f8, 3);
    endtask

    task automatic heavy_backpressure();
        ready_pct = 25;
        run_job(32'h0000_0500, 96);
    endtask

    task automatic back_to_back();
        ready_pct = 60;
        run_job(32'h0000_0800, 45);
        run_job(32'h0000_0a10, 20);
    endtask

    task automatic clear_mid_job();
        ready_pct = 50;
        start_job(32'h0000_0600, 64);
        collect_beats(32'h0000_0600, 64, 3);
        clear = 1'b1;
        repeat (2) begin
            next_cycle();
            check_equal(64'(busy_s), 64'd0, "busy after clear");
            check_equal(64'(valid_s), 64'd0, "beat valid after clear");
            check_equal(64'(req_s), 64'd0, "req after clear");
            check_equal(64'(done_s), 64'd0, "done after clear");
        end
        ready_pct = 70;
        run_job(32'h0000_0700, 27);
    endtask

    initial begin
        int waited;
        cfg        = '0;
        start      = 1'b0;
        clear      = 1'b0;
        gnt_en     = 1'b0;
        beat_ready = 1'b0;
        waited     = 0;
        while (rst_n !== 1'b1) begin  // reset is unknown until the clock source starts.
            @(posedge clk);
            waited++;
            if (waited > 20) abort_run("reset was never released");
        end
        next_cycle();
        check_equal(64'(req_s), 64'd0, "req after reset");
        check_equal(64'(valid_s), 64'd0, "beat valid after reset");
        check_equal(64'(done_s), 64'd0, "done after reset");
        check_equal(64'(busy_s), 64'd0, "busy after reset");
        aligned_length();
        odd_length();
        single_beat();
        heavy_backpressure();
        back_to_back();
        clear_mid_job();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* strm_load_top.f */
src/strm_cfg_pkg.sv
src/strm_beat_pkg.sv
src/strm_addr_gen.sv
src/strm_resp_fifo.sv
src/strm_strb_gen.sv
src/strm_load_top.sv
verif/tb_clk_gen.sv
verif/tb_mem_model.sv
verif/tb_strm_load_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_strm_load_top
FILELIST  := strm_load_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation passed

SRCS := $(wildcard src/*.sv) $(wildcard verif/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
